/* Bender.yml */
package:
  name: audio_filter

sources:
  - logic/fixed_point_pkg.sv
  - logic/filter_pkg.sv
  - logic/tap_history.sv
  - logic/mac_unit.sv
  - logic/iir_sequencer.sv
  - logic/level_meter.sv
  - logic/audio_filter_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_audio_filter.sv

/* logic/audio_filter_top.sv */
// Audio IIR filter top level
// One shared MAC stepped by the sequencer over both tap histories.
// Coefficients and output scale come in as a runtime struct.
// Level meter follows the filtered stream and drives a PWM LED.

`timescale 1ns/1ps
`default_nettype none

module audio_filter_top (
    input  wire logic                     state_clk,
    input  wire logic                     reset,
    input  wire filter_pkg::coeff_set_t   coeffs,
    input  wire filter_pkg::sample_beat_t in_beat,
    input  wire logic                     out_credit,
    output logic                          in_credit,
    output filter_pkg::sample_beat_t      out_beat,
    output fixed_point_pkg::sample_t      level,
    output logic                          led
);
    import fixed_point_pkg::*;
    import filter_pkg::*;

    tap_sel_t tap_sel;
    step_t    step;
    logic     acc_clear;
    logic     acc_en;
    logic     commit;
    fixed_t   x_new;                    // Current input, 3.24
    fixed_t   y_new;                    // Scaled result
    fixed_t   x_rd;
    fixed_t   y_rd;
    fixed_t   acc;
    fixed_t   coeff;
    fixed_t   operand;

    fixed_t [MAC_STEPS-1:0] coeff_tab;  // b taps low, a taps high

    ////////////////////////////////////////
    // Coefficient and operand select
    ////////////////////////////////////////

    assign coeff_tab = {coeffs.a, coeffs.b};
    assign coeff     = coeff_tab[step];     // Step order matches table

    always_comb
    begin
        case (tap_sel.src)
            SRC_X_HIST: operand = x_rd;
            SRC_Y_HIST: operand = y_rd;
            default:    operand = x_new;
        endcase
    end

    ////////////////////////////////////////
    // Instances
    ////////////////////////////////////////

    iir_sequencer u_seq (
        .state_clk (state_clk),
        .reset     (reset),
        .in_beat   (in_beat),
        .out_credit(out_credit),
        .scale     (coeffs.scale),
        .acc       (acc),
        .in_credit (in_credit),
        .out_beat  (out_beat),
        .tap_sel   (tap_sel),
        .step      (step),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .commit    (commit),
        .x_new     (x_new),
        .y_new     (y_new)
    );

    // Input history, x(n-1) onwards
    tap_history x_hist (
        .state_clk(state_clk),
        .reset    (reset),
        .shift_en (commit),
        .shift_in (x_new),
        .rd_idx   (tap_sel.idx),
        .rd_data  (x_rd)
    );

    // Output history, y(n-1) onwards
    tap_history y_hist (
        .state_clk(state_clk),
        .reset    (reset),
        .shift_en (commit),
        .shift_in (y_new),
        .rd_idx   (tap_sel.idx),
        .rd_data  (y_rd)
    );

    mac_unit u_mac (
        .state_clk(state_clk),
        .reset    (reset),
        .coeff    (coeff),
        .operand  (operand),
        .clear    (acc_clear),
        .en       (acc_en),
        .acc      (acc)
    );

    level_meter u_meter (
        .state_clk(state_clk),
        .reset    (reset),
        .out_beat (out_beat),
        .level    (level),
        .led      (led)
    );

endmodule

`default_nettype wire

/* logic/filter_pkg.sv */
// Filter structure definitions
// Tap counts follow from the filter order, any even order works
// Also holds the stream beat format, the MAC step select,
// the credit limits and the level meter constants

`default_nettype none

package filter_pkg;

    ////////////////////////////////////////
    // Structure
    ////////////////////////////////////////

    localparam int FILTER_ORDER = 4;
    localparam int NUM_B        = FILTER_ORDER + 1;     // b1 .. b(N+1)
    localparam int NUM_A        = FILTER_ORDER;         // a2 .. a(N+1)
    localparam int MAC_STEPS    = NUM_B + NUM_A;        // One MAC per tap

    localparam int STEP_W     = $clog2(MAC_STEPS);
    localparam int HIST_IDX_W = (FILTER_ORDER > 1) ? $clog2(FILTER_ORDER) : 1;

    ////////////////////////////////////////
    // Streams and meter
    ////////////////////////////////////////

    localparam int IN_CREDITS      = 1;                 // Input buffer depth
    localparam int OUT_CREDITS_MAX = 4;
    localparam int CREDIT_W        = $clog2(OUT_CREDITS_MAX + 1);

    localparam int METER_SHIFT   = 6;                   // ~64 sample decay
    localparam int METER_W       = fixed_point_pkg::SAMPLE_W + 2; // Headroom
    localparam int PWM_W         = 8;
    localparam int LED_SLICE_MSB = 13;                  // LED compares level[13:6]

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [STEP_W-1:0]     step_t;
    typedef logic [HIST_IDX_W-1:0] hist_idx_t;

    // Operand source of a MAC step
    typedef enum logic [1:0] {
        SRC_INPUT,      // Current sample x(n)
        SRC_X_HIST,     // x(n-1-idx)
        SRC_Y_HIST      // y(n-1-idx)
    } tap_src_t;

    typedef struct packed {
        tap_src_t  src;
        hist_idx_t idx;
    } tap_sel_t;

    // Feedback coefficients arrive negated, so every step adds
    typedef struct packed {
        fixed_point_pkg::fixed_t [NUM_B-1:0] b;
        fixed_point_pkg::fixed_t [NUM_A-1:0] a;
        fixed_point_pkg::scale_t             scale;
    } coeff_set_t;

    typedef struct packed {
        logic                    valid;
        fixed_point_pkg::sample_t data;
    } sample_beat_t;

endpackage

`default_nettype wire

/* logic/fixed_point_pkg.sv */
// Fixed-point number formats for the audio filter datapath
// Audio samples are 16-bit two's complement
// Internal words are 3.24 signed, 27 bits wide
// Products of two internal words are 6.48, 54 bits wide

`default_nettype none

package fixed_point_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int SAMPLE_W = 16;                   // Codec sample width
    localparam int FIX_W    = 27;                   // 3 integer bits incl. sign
    localparam int FRAC_W   = 24;                   // Fraction bits

    // Sample sits in the top bits of an internal word
    localparam int SAMPLE_SHIFT = FIX_W - SAMPLE_W; // 11

    localparam int SCALE_W = 3;                     // Output shift, 0 to 7
    localparam int PROD_W  = 2 * FIX_W;             // Full multiplier result

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // One audio sample
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // One 3.24 value
    typedef logic signed [FIX_W-1:0] fixed_t;

    // Full-width 6.48 product
    typedef logic signed [PROD_W-1:0] product_t;

    // Left shift applied to the accumulator on write-back
    // Undoes the coefficient down-scaling that keeps |coeff| < 2
    typedef logic [SCALE_W-1:0] scale_t;

endpackage

`default_nettype wire

/* logic/iir_sequencer.sv */
// IIR sequencer
// Buffers one input sample, tracks output credits and steps the
// shared MAC through all feedforward and feedback taps per sample.
// Final cycle scales the accumulator into the output sample and
// the two history write values.

`timescale 1ns/1ps
`default_nettype none

module iir_sequencer (
    input  wire logic                       state_clk,
    input  wire logic                       reset,
    input  wire filter_pkg::sample_beat_t   in_beat,
    input  wire logic                       out_credit,
    input  wire fixed_point_pkg::scale_t    scale,
    input  wire fixed_point_pkg::fixed_t    acc,
    output logic                            in_credit,
    output filter_pkg::sample_beat_t        out_beat,
    output filter_pkg::tap_sel_t            tap_sel,
    output filter_pkg::step_t               step,
    output logic                            acc_clear,
    output logic                            acc_en,
    output logic                            commit,
    output fixed_point_pkg::fixed_t         x_new,
    output fixed_point_pkg::fixed_t         y_new
);
    import fixed_point_pkg::*;
    import filter_pkg::*;

    typedef enum logic [1:0] {PH_IDLE, PH_RUN, PH_COMMIT} phase_t;

    phase_t              phase;
    logic                start;         // Sample enters computation
    logic                buf_full;
    sample_t             buf_data;      // One-entry input buffer
    fixed_t              x_cur;         // Sample under computation, 3.24
    logic [CREDIT_W-1:0] out_credits;   // Output credits held
    logic                out_valid;
    sample_t             out_data;

    ////////////////////////////////////////
    // Input buffer and credits
    ////////////////////////////////////////

    assign start     = (phase == PH_IDLE) && buf_full && (out_credits != '0);
    assign in_credit = start;           // Buffer slot freed this cycle

    always_ff @(posedge state_clk)
    begin
        if (reset)
            buf_full <= 1'b0;
        else if (in_beat.valid)
            buf_full <= 1'b1;           // Source holds a credit, slot is empty
        else if (start)
            buf_full <= 1'b0;
    end

    always_ff @(posedge state_clk)
    begin
        if (in_beat.valid)
            buf_data <= in_beat.data;
        if (start)
            x_cur <= {buf_data, {SAMPLE_SHIFT{1'b0}}};  // Widen to 3.24
    end

    // Sink grants, start reserves
    always_ff @(posedge state_clk)
    begin
        if (reset)
            out_credits <= '0;
        else
            out_credits <= out_credits + CREDIT_W'(out_credit) - CREDIT_W'(start);
    end

    ////////////////////////////////////////
    // Step FSM
    ////////////////////////////////////////

    always_ff @(posedge state_clk)
    begin
        if (reset)
        begin
            phase <= PH_IDLE;
            step  <= '0;
        end
        else
        begin
            case (phase)
                PH_IDLE:
                begin
                    step <= '0;
                    if (start)
                        phase <= PH_RUN;
                end
                PH_RUN:
                begin
                    if (step == step_t'(MAC_STEPS - 1))
                        phase <= PH_COMMIT;     // Last tap in, acc settles
                    else
                        step <= step + 1'b1;
                end
                default:
                    phase <= PH_IDLE;           // Commit lasts one cycle
            endcase
        end
    end

    assign acc_clear = (phase == PH_RUN) && (step == '0);  // b1 * x(n) first
    assign acc_en    = (phase == PH_RUN) && (step != '0);
    assign commit    = (phase == PH_COMMIT);

    // Steps 0..NUM_B-1 feedforward, then feedback
    always_comb
    begin
        tap_sel.src = SRC_INPUT;
        tap_sel.idx = '0;
        if (step >= step_t'(NUM_B))
        begin
            tap_sel.src = SRC_Y_HIST;
            tap_sel.idx = hist_idx_t'(step - step_t'(NUM_B));
        end
        else if (step != '0)
        begin
            tap_sel.src = SRC_X_HIST;
            tap_sel.idx = hist_idx_t'(step - 1'b1);
        end
    end

    ////////////////////////////////////////
    // Write-back
    ////////////////////////////////////////

    assign x_new = x_cur;
    assign y_new = acc <<< scale;       // Undo coefficient scaling, wraps

    always_ff @(posedge state_clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= commit;
    end

    always_ff @(posedge state_clk)
    begin
        if (commit)
            out_data <= y_new[FIX_W-1 -: SAMPLE_W];     // Bits 26..11
    end

    assign out_beat = '{valid: out_valid, data: out_data};

endmodule

`default_nettype wire

/* logic/level_meter.sv */
// Level meter
// Time-weighted average of output magnitude, first order lowpass
// with a 2^METER_SHIFT sample decay. A free-running PWM counter
// compares against a slice of the average to dim an LED.

`timescale 1ns/1ps
`default_nettype none

module level_meter (
    input  wire logic                     state_clk,
    input  wire logic                     reset,
    input  wire filter_pkg::sample_beat_t out_beat,
    output fixed_point_pkg::sample_t      level,
    output logic                          led
);
    import fixed_point_pkg::*;
    import filter_pkg::*;

    logic signed [METER_W-1:0] mag;         // |sample|, -32768 fits
    logic signed [METER_W-1:0] level_ext;
    logic signed [METER_W-1:0] avg_next;
    logic                      avg_sat;     // Above max positive sample
    logic [PWM_W-1:0]          pwm_cnt;

    ////////////////////////////////////////
    // Averager
    ////////////////////////////////////////

    assign mag = out_beat.data[SAMPLE_W-1] ? -METER_W'(out_beat.data)
                                           : METER_W'(out_beat.data);
    assign level_ext = METER_W'(level);

    // Loses its own share, gains the new sample's share
    assign avg_next = level_ext - (level_ext >>> METER_SHIFT) + (mag >>> METER_SHIFT);
    assign avg_sat  = |avg_next[METER_W-1:SAMPLE_W-1];  // Never negative

    always_ff @(posedge state_clk)
    begin
        if (reset)
            level <= '0;
        else if (out_beat.valid)
            level <= avg_sat ? {1'b0, {(SAMPLE_W-1){1'b1}}}
                             : avg_next[SAMPLE_W-1:0];
    end

    ////////////////////////////////////////
    // PWM
    ////////////////////////////////////////

    // Duty is slice+1 of 2^PWM_W, fully dark at zero average
    always_ff @(posedge state_clk)
    begin
        if (reset)
        begin
            pwm_cnt <= '0;
            led     <= 1'b0;
        end
        else
        begin
            pwm_cnt <= pwm_cnt + 1'b1;      // Free running
            led     <= (level != '0) && (pwm_cnt <= level[LED_SLICE_MSB -: PWM_W]);
        end
    end

endmodule

`default_nettype wire

/* logic/mac_unit.sv */
// Multiply-accumulate unit, 3.24 signed
// Full 6.48 product, truncated back to 3.24 keeping its sign,
// then loaded or added into the accumulator register

`timescale 1ns/1ps
`default_nettype none

module mac_unit (
    input  wire logic                    state_clk,
    input  wire logic                    reset,
    input  wire fixed_point_pkg::fixed_t coeff,
    input  wire fixed_point_pkg::fixed_t operand,
    input  wire logic                    clear,
    input  wire logic                    en,
    output fixed_point_pkg::fixed_t      acc
);
    import fixed_point_pkg::*;

    product_t product;      // 6.48
    fixed_t   term;         // Product back in 3.24

    ////////////////////////////////////////
    // Multiply
    ////////////////////////////////////////

    assign product = coeff * operand;

    // Sign bit, then 2 integer and 24 fraction bits
    // Upper integer bits drop, low fraction bits truncate
    assign term = {product[PROD_W-1], product[FIX_W+FRAC_W-2 : FRAC_W]};

    ////////////////////////////////////////
    // Accumulate
    ////////////////////////////////////////

    always_ff @(posedge state_clk)
    begin
        if (reset)
            acc <= '0;
        else if (clear)
            acc <= term;            // First tap of a sample
        else if (en)
            acc <= acc + term;      // Wraps on overflow
    end

endmodule

`default_nettype wire

/* logic/tap_history.sv */
// Tap history delay line
// Holds the last FILTER_ORDER values in 3.24 format
// Entry 0 is the newest. Shifts one place on commit,
// read port is combinational and indexed

`timescale 1ns/1ps
`default_nettype none

module tap_history (
    input  wire logic                    state_clk,
    input  wire logic                    reset,
    input  wire logic                    shift_en,
    input  wire fixed_point_pkg::fixed_t shift_in,
    input  wire filter_pkg::hist_idx_t   rd_idx,
    output fixed_point_pkg::fixed_t      rd_data
);
    import fixed_point_pkg::*;
    import filter_pkg::*;

    fixed_t taps [FILTER_ORDER];        // taps[k] is value (n-1-k)

    ////////////////////////////////////////
    // Shift
    ////////////////////////////////////////

    // Filter state starts from silence
    always_ff @(posedge state_clk)
    begin
        if (reset)
        begin
            taps <= '{default: '0};
        end
        else if (shift_en)
        begin
            taps[0] <= shift_in;                        // Newest in
            for (int i = 1; i < FILTER_ORDER; i++)
            begin
                taps[i] <= taps[i-1];                   // Oldest falls off
            end
        end
    end

    ////////////////////////////////////////
    // Read
    ////////////////////////////////////////

    // Index always below FILTER_ORDER from the sequencer
    assign rd_data = taps[rd_idx];

endmodule

`default_nettype wire

/* sim.f */
+incdir+sim
logic/fixed_point_pkg.sv
logic/filter_pkg.sv
logic/tap_history.sv
logic/mac_unit.sv
logic/iir_sequencer.sv
logic/level_meter.sv
logic/audio_filter_top.sv
sim/tb_audio_filter.sv

/* sim/tb_reference_model.svh */
// Reference model of the audio IIR filter and its level meter
// Bit-exact 3.24 arithmetic, one call per input sample
// Included in the testbench module after the package imports

`ifndef TB_REFERENCE_MODEL_SVH
`define TB_REFERENCE_MODEL_SVH

fixed_t ref_x [FILTER_ORDER];       // x(n-1) first
fixed_t ref_y [FILTER_ORDER];       // y(n-1) first
int     ref_level;                  // Averaged magnitude

// 3.24 times 3.24, back to 3.24 with the sign bit kept
function automatic fixed_t mul_trunc(input fixed_t c, input fixed_t v);
    logic signed [2*FIX_W-1:0] p;   // 6.48
    p = c * v;
    return {p[2*FIX_W-1], p[FRAC_W +: FIX_W-1]};
endfunction

task automatic ref_reset();
    ref_x     = '{default: '0};
    ref_y     = '{default: '0};
    ref_level = 0;
endtask

// One sample through the filter, histories move on
task automatic ref_filter(input coeff_set_t c, input sample_t s, output sample_t y_out);
    fixed_t x0;
    fixed_t acc;
    fixed_t y;
    x0  = fixed_t'(s) <<< SAMPLE_SHIFT;             // Sample in the top 16 bits
    acc = mul_trunc(c.b[0], x0);
    for (int k = 1; k < NUM_B; k++)
        acc += mul_trunc(c.b[k], ref_x[k-1]);       // Feedforward
    for (int k = 0; k < NUM_A; k++)
        acc += mul_trunc(c.a[k], ref_y[k]);         // Feedback, already negated
    y = acc <<< c.scale;
    for (int k = FILTER_ORDER - 1; k > 0; k--)
    begin
        ref_x[k] = ref_x[k-1];
        ref_y[k] = ref_y[k-1];
    end
    ref_x[0] = x0;
    ref_y[0] = y;
    y_out    = y[FIX_W-1 -: SAMPLE_W];              // Bits 26 to 11
endtask

// Averager step on one output sample, clamps at max positive
task automatic ref_level_update(input sample_t s);
    int mag;
    mag = (s < 0) ? -int'(s) : int'(s);
    ref_level = ref_level - ref_level / (2 ** METER_SHIFT) + mag / (2 ** METER_SHIFT);
    if (ref_level > 32767)
        ref_level = 32767;
endtask

`endif

/* sim/tb_audio_filter.sv */
// Testbench for the audio IIR filter
// LFSR samples go in over the credit input stream, a sink grants
// output credits with random gaps. Outputs, level and LED duty
// are compared against a bit-exact reference model.

`timescale 1ns/1ps
`default_nettype none

module tb_audio_filter;
    import fixed_point_pkg::*;
    import filter_pkg::*;

    localparam int IMPULSE_LEN    = 24;
    localparam int RANDOM_LEN     = 200;
    localparam int TOTAL_SAMPLES  = IMPULSE_LEN + RANDOM_LEN;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_SAMPLES * (MAC_STEPS + 4);
    localparam int STARVE_CYCLES  = 150;    // Output credits held back

    logic         state_clk;
    logic         reset;
    coeff_set_t   coeffs;
    sample_beat_t in_beat;
    logic         out_credit;
    logic         in_credit;
    sample_beat_t out_beat;
    sample_t      level;
    logic         led;

    // Stream bookkeeping
    int beats_sent      = 0;
    int in_credit_cnt   = 0;    // Credits returned to the source
    int grants          = 0;    // Credits given by the sink
    int out_cnt         = 0;
    int starved_returns = 0;
    int cycles          = 0;
    int data_errors     = 0;
    int protocol_errors = 0;

    logic       sink_on = 1'b0;
    logic       hold    = 1'b0;     // Sink pauses
    logic       starved = 1'b0;     // Pause with nothing in flight
    logic [15:0] src_lfsr  = 16'd74;
    logic [15:0] sink_lfsr = 16'd74;

    sample_t exp_q [$];             // Expected outputs in order
    sample_t exp_front = '0;
    int      exp_count = 0;

    `include "tb_reference_model.svh"

    audio_filter_top uut (
        .state_clk (state_clk),
        .reset     (reset),
        .coeffs    (coeffs),
        .in_beat   (in_beat),
        .out_credit(out_credit),
        .in_credit (in_credit),
        .out_beat  (out_beat),
        .level     (level),
        .led       (led)
    );

    initial
    begin
        state_clk = 1'b0;
        forever #20 state_clk = ~state_clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int n, output int unsigned value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            state = lfsr_step(state);           // One step per bit
            value = (value << 1) | state[0];
        end
    endtask

    // 4th order bandpass near fs/8, coefficients scaled by 1/4
    function automatic coeff_set_t bandpass_coeffs();
        coeff_set_t c;
        c.b[0]  = 27'sd37854;
        c.b[1]  = 27'sd0;
        c.b[2]  = -27'sd75708;
        c.b[3]  = 27'sd0;
        c.b[4]  = 27'sd37854;
        c.a[0]  = 27'sd10676953;
        c.a[1]  = -27'sd13589545;
        c.a[2]  = 27'sd8648403;
        c.a[3]  = -27'sd2751883;
        c.scale = 3'd2;                         // Undo the 1/4
        return c;
    endfunction

    function automatic void refresh_front();
        exp_count = exp_q.size();
        exp_front = (exp_q.size() != 0) ? exp_q[0] : '0;
    endfunction

    task automatic send_sample(input sample_t s);
        sample_t y_exp;
        while (IN_CREDITS + in_credit_cnt - beats_sent <= 0)
            @(posedge state_clk);               // Wait for a credit
        in_beat <= '{valid: 1'b1, data: s};
        beats_sent++;
        ref_filter(coeffs, s, y_exp);
        exp_q.push_back(y_exp);
        refresh_front();
        @(posedge state_clk);
        in_beat <= '{valid: 1'b0, data: '0};
    endtask

    task automatic send_random(input int n);
        int unsigned v;
        for (int i = 0; i < n; i++)
        begin
            draw_bits(src_lfsr, 15, v);
            send_sample(sample_t'(int'(v) - 16384));    // +-2.0 in 3.24
        end
    endtask

    task automatic wait_drain();
        while (out_cnt != beats_sent)
            @(posedge state_clk);
    endtask

    // Pause credits mid stream, let the DUT run dry, then starve it
    task automatic starve_outputs();
        repeat (400) @(posedge state_clk);
        hold <= 1'b1;
        @(posedge state_clk);
        while (grants != out_cnt)
            @(posedge state_clk);
        starved <= 1'b1;
        repeat (STARVE_CYCLES) @(posedge state_clk);
        starved <= 1'b0;
        hold    <= 1'b0;
    endtask

    // LED duty over one full PWM period
    task automatic check_led_window();
        int high_cycles;
        int expected_high;
        high_cycles = 0;
        repeat (4) @(posedge state_clk);        // Level settled
        repeat (2 ** PWM_W)
        begin
            @(posedge state_clk);
            high_cycles += int'(led);
        end
        expected_high = (ref_level == 0) ? 0
                      : ((ref_level >> (14 - PWM_W)) % (2 ** PWM_W)) + 1;
        assert (high_cycles == expected_high)
        else
        begin
            data_errors++;
            $display("[ERROR] %0t led high cycles got %0d expected %0d",
                     $time, high_cycles, expected_high);
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d samples in, %0d out, %0d data errors, %0d protocol errors",
                 beats_sent, out_cnt, data_errors, protocol_errors);
    endtask

    ////////////////////////////////////////
    // Sink and monitor
    ////////////////////////////////////////

    initial
    begin : sink
        int unsigned gap;
        gap        = 0;
        out_credit = 1'b0;
        forever
        begin
            @(posedge state_clk);
            out_credit <= 1'b0;
            if (sink_on && !hold && (grants - out_cnt) < OUT_CREDITS_MAX)
            begin
                if (gap == 0)
                begin
                    out_credit <= 1'b1;
                    grants++;
                    draw_bits(sink_lfsr, 3, gap);   // 0 to 7 idle cycles
                end
                else
                    gap--;
            end
        end
    end

    always @(posedge state_clk)
    begin : monitor
        sample_t popped;
        if (!reset)
        begin
            if (in_credit)
                in_credit_cnt <= in_credit_cnt + 1;
            if (in_credit && starved)
                starved_returns <= starved_returns + 1;
            if (out_beat.valid)
            begin
                out_cnt <= out_cnt + 1;
                if (exp_q.size() != 0)
                begin
                    popped = exp_q.pop_front();
                    ref_level_update(popped);       // Meter follows the model
                end
                refresh_front();
            end
        end
    end

    always @(posedge state_clk)
    begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Run stopped after %0d cycles, %0d of %0d samples came out",
                     cycles, out_cnt, TOTAL_SAMPLES);
            print_summary();
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    out_data_check: assert property (@(posedge state_clk) disable iff (reset)
        out_beat.valid |-> out_beat.data == exp_front)
    else
    begin
        data_errors++;
        $display("[ERROR] %0t out_beat.data got %0d expected %0d",
                 $time, $sampled(out_beat.data), $sampled(exp_front));
    end

    out_order_check: assert property (@(posedge state_clk) disable iff (reset)
        out_beat.valid |-> exp_count != 0)
    else
    begin
        protocol_errors++;
        $display("Output beat at %0t with no input sample left to match", $time);
    end

    out_credit_check: assert property (@(posedge state_clk) disable iff (reset)
        out_beat.valid |-> (grants - out_cnt) > 0)
    else
    begin
        protocol_errors++;
        $display("Output beat at %0t sent without an outstanding credit", $time);
    end

    in_credit_check: assert property (@(posedge state_clk) disable iff (reset)
        in_credit |-> (IN_CREDITS + in_credit_cnt - beats_sent) == 0)
    else
    begin
        protocol_errors++;
        $display("Input credit at %0t returned while the source still held one", $time);
    end

    starve_check: assert property (@(posedge state_clk) disable iff (reset)
        (starved && in_credit) |-> starved_returns == 0)
    else
    begin
        protocol_errors++;
        $display("Second input credit at %0t while output credits were withheld", $time);
    end

    idle_check: assert property (@(posedge state_clk) disable iff (reset)
        (grants == 0) |-> !(out_beat.valid || in_credit || led))
    else
    begin
        protocol_errors++;
        $display("DUT active at %0t before any output credit was granted", $time);
    end

    level_check: assert property (@(posedge state_clk) disable iff (reset)
        level == sample_t'(ref_level))
    else
    begin
        data_errors++;
        $display("[ERROR] %0t level got %0d expected %0d",
                 $time, $sampled(level), $sampled(ref_level));
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin : main
        reset   = 1'b1;
        coeffs  = bandpass_coeffs();
        in_beat = '0;
        ref_reset();
        repeat (3) @(posedge state_clk);
        reset <= 1'b0;

        // Impulse sits in the buffer until credits show up
        send_sample(sample_t'(32767));
        repeat (20) @(posedge state_clk);
        sink_on <= 1'b1;
        for (int i = 1; i < IMPULSE_LEN; i++)
            send_sample('0);
        wait_drain();

        fork
            send_random(RANDOM_LEN);
            starve_outputs();
        join
        wait_drain();

        check_led_window();
        repeat (20) @(posedge state_clk);      // Room for stray beats
        assert (out_cnt == TOTAL_SAMPLES)
        else
        begin
            protocol_errors++;
            $display("[ERROR] %0t output count got %0d expected %0d",
                     $time, out_cnt, TOTAL_SAMPLES);
        end

        print_summary();
        if (data_errors + protocol_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
